/* cplx_pe.f */
logic/cplx_pe_pkg.sv
logic/pe_inst_mem.sv
logic/pe_data_mem.sv
logic/complex_alu.sv
logic/pe_control.sv
logic/cplx_pe_top.sv
bench/cplx_pe_tb.sv

/* bench/cplx_pe_cases.txt */
# case <name> <credit mode, 0 prompt, 1 throttled> <data words> <program words> <expected words>
# each header is followed by its data, program and expected words in hex, in that order

# add and sub, 16-bit wraparound on both parts
case addsub 0 4 9 4
40002000 1000e000 70008000 2000ffff
040040 250040 0610c0 271880
602000 602800 603000 603800
800000
50000000 30004000 90007fff b0007fff

# q1.15 multiply, negative parts, floor on the shift, -1 times -1 wraps
case mul 0 5 11 5
40004000 4000c000 80000000 6000a000 0003fffd
450040 4610c0 471080 481900 492000
602800 603000 603800 604000 604800
800000
40000000 a0006000 80000000 0000fffb 00030000

# dependent chain, each step reads the one before it
case chain 0 3 9 3
01000200 00100020 40000000
030040 031840 241800 452080 452940
601800 602000 602800
800000
01200240 00200040 ffff0000

# more outputs than credits, slow credit return, runs off the program end
case throttle 1 2 10 8
11112222 01010202
020040 230040
600000 600800 601000 601800
600000 601000 601800 600800
11112222 01010202 12122424
10102020 11112222 12122424
10102020 01010202

# no data load, works on what the earlier programs left behind
case reuse 1 0 8 4
0a10c0 2b3100 4c3a00
605000 605800 606000 602800
800000
22224444 9fe05fc0 00000005 ffff0000

/* bench/cplx_pe_tb.sv */
`timescale 1ns/1ps

module cplx_pe_tb;
    import cplx_pe_pkg::*;

    localparam int OUT_CREDITS = 4;
    localparam int MAX_CASES   = 16;
    localparam int POOL        = 256;

    logic  clk;
    logic  arst_n;
    logic  din_v;
    cplx_t din;
    logic  inst_v;
    inst_t inst;
    logic  start;
    logic  dout_v;
    cplx_t dout;
    logic  credit_in;
    logic  busy;
    logic  done;

    // case table filled once from the cases file
    logic [127:0]              case_name [MAX_CASES];
    int                        case_mode [MAX_CASES];
    int                        case_nd   [MAX_CASES];
    int                        case_np   [MAX_CASES];
    int                        case_ne   [MAX_CASES];
    logic [31:0]               data_pool [POOL];
    logic [$bits(inst_t)-1:0]  prog_pool [POOL];
    logic [31:0]               exp_pool  [POOL];
    int                        n_cases = 0;

    // run bookkeeping shared by the monitor and credit model
    int          cycles        = 0;
    int          cycle_limit   = 0;
    int          errors        = 0;
    int          exp_base      = 0;
    int          exp_count     = 0;
    int          case_base     = 0;
    int          recv_total    = 0;
    int          credits_given = 0;
    int          wait_left     = 0;
    int          throttled     = 0;
    logic [15:0] lfsr          = 16'd26430;

    cplx_pe_top uut (
        .clk, .arst_n, .din_v, .din, .inst_v, .inst, .start,
        .dout_v, .dout, .credit_in, .busy, .done
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic expect_low(input string sig, input logic value);
        if (value !== 1'b0) begin
            $display("ERR %s: got %h, expected 0", sig, value);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cases file reader
    ////////////////////////////////////////////////////////////

    task automatic read_cases();
        int               fd;
        int               code;
        int               got;
        int               d_ptr;
        int               p_ptr;
        int               e_ptr;
        logic [127:0]     tok;
        logic [8*120-1:0] rest;
        d_ptr = 0;
        p_ptr = 0;
        e_ptr = 0;
        fd = $fopen("bench/cplx_pe_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/cplx_pe_cases.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                // rest of a comment line
                code = $fgets(rest, fd);
            end else if (tok == "case") begin
                code = $fscanf(fd, "%s %d %d %d %d", case_name[n_cases], case_mode[n_cases],
                               case_nd[n_cases], case_np[n_cases], case_ne[n_cases]);
                got = 0;
                for (int i = 0; i < case_nd[n_cases]; i++) begin
                    got += $fscanf(fd, "%h", data_pool[d_ptr]);
                    d_ptr++;
                end
                for (int i = 0; i < case_np[n_cases]; i++) begin
                    got += $fscanf(fd, "%h", prog_pool[p_ptr]);
                    p_ptr++;
                end
                for (int i = 0; i < case_ne[n_cases]; i++) begin
                    got += $fscanf(fd, "%h", exp_pool[e_ptr]);
                    e_ptr++;
                end
                if (code != 5
                    || got != case_nd[n_cases] + case_np[n_cases] + case_ne[n_cases]) begin
                    $display("case %0d in the cases file is incomplete", n_cases);
                    errors++;
                end
                n_cases++;
            end else begin
                $display("cases file holds a token that is neither a comment nor a case");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor and credit model
    ////////////////////////////////////////////////////////////

    // sample mid cycle while dout is stable
    always @(negedge clk) begin : dout_monitor
        int idx;
        if (arst_n && dout_v === 1'b1) begin
            idx = recv_total - case_base;
            if (idx >= exp_count) begin
                $display("unexpected extra word %h on dout", dout);
                errors++;
            end else if (dout !== exp_pool[exp_base + idx]) begin
                $display("ERR dout: got %h, expected %h", dout, exp_pool[exp_base + idx]);
                errors++;
            end
            if (recv_total + 1 > credits_given + OUT_CREDITS) begin
                $display("word sent with no credit left, %0d words against %0d credits back",
                         recv_total + 1, credits_given);
                errors++;
            end
            recv_total++;
        end
    end

    // one credit per word received
    // throttled mode waits an lfsr gap of 0..7 cycles
    always @(posedge clk) begin : credit_model
        logic [2:0] gap;
        #2;
        credit_in = 1'b0;
        if (!arst_n) begin
            wait_left = 0;
        end else if (wait_left > 0) begin
            wait_left--;
        end else if (credits_given < recv_total) begin
            credit_in = 1'b1;
            credits_given++;
            if (throttled != 0) begin
                gap = '0;
                for (int i = 0; i < 3; i++) begin
                    lfsr = lfsr_next(lfsr);
                    gap  = {gap[1:0], lfsr[0]};
                end
                wait_left = gap;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run timed out after %0d cycles while waiting for done", cycles);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        int d_ptr;
        int p_ptr;
        int e_ptr;
        int case_err;
        arst_n    = 1'b0;
        din_v     = 1'b0;
        din       = '0;
        inst_v    = 1'b0;
        inst      = '0;
        start     = 1'b0;
        credit_in = 1'b0;
        d_ptr     = 0;
        p_ptr     = 0;
        e_ptr     = 0;
        read_cases();
        if (n_cases == 0) begin
            $display("no test cases were read from the cases file");
            errors++;
        end
        // budget of 8 cycles per instruction plus 20 per case
        for (int c = 0; c < n_cases; c++) begin
            cycle_limit += 8 * case_np[c] + 20;
        end
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;

        // outputs quiet before any start
        @(negedge clk);
        case_err = errors;
        expect_low("dout_v", dout_v);
        expect_low("busy", busy);
        expect_low("done", done);
        $display("reset idle: %0s", (errors == case_err) ? "pass" : "fail");

        for (int c = 0; c < n_cases; c++) begin
            case_err = errors;
            @(posedge clk);
            #2;
            throttled = case_mode[c];
            // data stream then program words
            for (int i = 0; i < case_nd[c]; i++) begin
                din_v = 1'b1;
                din   = data_pool[d_ptr];
                d_ptr++;
                @(posedge clk);
                #2;
            end
            din_v = 1'b0;
            for (int i = 0; i < case_np[c]; i++) begin
                inst_v = 1'b1;
                inst   = prog_pool[p_ptr];
                p_ptr++;
                @(posedge clk);
                #2;
            end
            inst_v    = 1'b0;
            exp_base  = e_ptr;
            exp_count = case_ne[c];
            case_base = recv_total;
            start     = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
            @(negedge clk);
            while (done !== 1'b1) begin
                @(negedge clk);
            end
            @(posedge clk);
            // every expected word in before done
            if (recv_total - case_base != exp_count) begin
                $display("done came after %0d of %0d expected words",
                         recv_total - case_base, exp_count);
                errors++;
            end
            e_ptr += case_ne[c];
            $display("case %0s: %0d words, %0s", case_name[c], recv_total - case_base,
                     (errors == case_err) ? "pass" : "fail");
        end

        $display("%0d cases run, %0d words checked, %0d errors", n_cases, recv_total, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* logic/cplx_pe_top.sv */
`timescale 1ns/1ps

module cplx_pe_top #(
    parameter int OUT_CREDITS = 4,
    parameter int PROG_DEPTH  = 16
) (
    input  logic               clk,
    input  logic               arst_n,
    // data load stream
    input  logic               din_v,
    input  cplx_pe_pkg::cplx_t din,
    // program load
    input  logic               inst_v,
    input  cplx_pe_pkg::inst_t inst,
    input  logic               start,
    // credit flow output
    output logic               dout_v,
    output cplx_pe_pkg::cplx_t dout,
    input  logic               credit_in,
    // status
    output logic               busy,
    output logic               done
);
    import cplx_pe_pkg::*;

    // program side
    inst_t    cur_inst;
    logic     pc_end;
    logic     pc_step;
    // data memory ports
    addr_t    raddr_a;
    addr_t    raddr_b;
    cplx_t    rdata_a;
    cplx_t    rdata_b;
    logic     we;
    addr_t    waddr;
    cplx_t    wdata;
    // alu pipe
    alu_req_t alu_req;
    alu_rsp_t alu_rsp;

    pe_inst_mem #(.PROG_DEPTH(PROG_DEPTH)) u_imem (
        .clk, .arst_n, .inst_v, .inst, .start, .pc_step, .cur_inst, .pc_end
    );

    pe_data_mem u_dmem (
        .clk, .arst_n, .we, .waddr, .wdata, .raddr_a, .raddr_b, .rdata_a, .rdata_b
    );

    complex_alu u_alu (
        .clk, .arst_n, .req(alu_req), .rsp(alu_rsp)
    );

    pe_control #(.OUT_CREDITS(OUT_CREDITS)) u_ctrl (
        .clk, .arst_n, .din_v, .din, .start,
        .cur_inst, .pc_end, .pc_step,
        .raddr_a, .raddr_b, .rdata_a, .rdata_b,
        .we, .waddr, .wdata,
        .alu_req, .alu_rsp,
        .dout_v, .dout, .credit_in,
        .busy, .done
    );

endmodule

/* logic/pe_control.sv */
`timescale 1ns/1ps

module pe_control #(
    parameter int OUT_CREDITS = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  din_v,
    input  cplx_pe_pkg::cplx_t    din,
    input  logic                  start,
    input  cplx_pe_pkg::inst_t    cur_inst,
    input  logic                  pc_end,
    output logic                  pc_step,
    output cplx_pe_pkg::addr_t    raddr_a,
    output cplx_pe_pkg::addr_t    raddr_b,
    input  cplx_pe_pkg::cplx_t    rdata_a,
    input  cplx_pe_pkg::cplx_t    rdata_b,
    output logic                  we,
    output cplx_pe_pkg::addr_t    waddr,
    output cplx_pe_pkg::cplx_t    wdata,
    output cplx_pe_pkg::alu_req_t alu_req,
    input  cplx_pe_pkg::alu_rsp_t alu_rsp,
    output logic                  dout_v,
    output cplx_pe_pkg::cplx_t    dout,
    input  logic                  credit_in,
    output logic                  busy,
    output logic                  done
);
    import cplx_pe_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    typedef enum logic [1:0] {IDLE, RUN, DRAIN, FINISH} state_e;

    state_e             state;
    state_e             state_nx;
    addr_t              load_ptr;
    logic [CW-1:0]      credits;
    // scoreboard, entry 0 issued last cycle
    logic [ALU_LAT-1:0] sb_v;
    addr_t              sb_dst [ALU_LAT];
    logic               is_arith;
    logic               is_out;
    logic               is_halt;
    logic               hazard_a;
    logic               hazard_b;
    logic               credit_ok;
    logic               issue;
    logic               pipe_empty;

    assign busy       = (state == RUN) || (state == DRAIN);
    assign done       = (state == FINISH);
    assign pipe_empty = ~|sb_v;

    ////////////////////////////////////////////////////////////
    // issue decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        is_arith = cur_inst.opcode inside {OP_ADD, OP_SUB, OP_MUL};
        is_out   = (cur_inst.opcode == OP_OUT);
        // unknown opcodes stop the program like halt
        is_halt  = pc_end || !(is_arith || is_out);
        hazard_a = 1'b0;
        hazard_b = 1'b0;
        for (int i = 0; i < ALU_LAT; i++) begin
            if (sb_v[i] && (sb_dst[i] == cur_inst.src_a)) begin
                hazard_a = 1'b1;
            end
            if (sb_v[i] && (sb_dst[i] == cur_inst.src_b)) begin
                hazard_b = 1'b1;
            end
        end
        // word on dout this cycle still holds a credit
        credit_ok = credits > CW'(dout_v);
        issue = (state == RUN) && !is_halt && !hazard_a
              && !(is_arith && hazard_b) && !(is_out && !credit_ok);
    end

    assign pc_step = issue;
    assign raddr_a = cur_inst.src_a;
    assign raddr_b = cur_inst.src_b;
    assign alu_req = '{valid: issue && is_arith, op: cur_inst.opcode,
                       dst: cur_inst.dst, a: rdata_a, b: rdata_b};

    // write port, load stream when idle, writeback during a run
    always_comb begin
        if (busy) begin
            we    = alu_rsp.valid;
            waddr = alu_rsp.dst;
            wdata = alu_rsp.result;
        end else begin
            we    = din_v;
            waddr = load_ptr;
            wdata = din;
        end
    end

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (start) state_nx = RUN;
            RUN:     if (is_halt) state_nx = pipe_empty ? FINISH : DRAIN;
            DRAIN:   if (pipe_empty) state_nx = FINISH;
            FINISH:  state_nx = start ? RUN : IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            load_ptr <= '0;
            credits  <= CW'(OUT_CREDITS);
            sb_v     <= '0;
            dout_v   <= 1'b0;
        end else begin
            state <= state_nx;
            if (start && !busy) begin
                load_ptr <= '0;
            end else if (din_v && !busy) begin
                load_ptr <= load_ptr + 1'b1;
            end
            // word leaving costs one, credit back returns one
            credits <= credits + CW'(credit_in) - CW'(dout_v);
            sb_v    <= {sb_v[ALU_LAT-2:0], alu_req.valid};
            dout_v  <= issue && is_out;
        end
    end

    // tags and output word
    always_ff @(posedge clk) begin
        sb_dst[0] <= cur_inst.dst;
        for (int i = 1; i < ALU_LAT; i++) begin
            sb_dst[i] <= sb_dst[i-1];
        end
        if (issue && is_out) begin
            dout <= rdata_a;
        end
    end

    a_credit_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n) dout_v |-> (credits != '0)
    );
    a_credit_limit: assert property (
        @(posedge clk) disable iff (!arst_n) credit_in |-> (credits != CW'(OUT_CREDITS))
    );
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !din_v
    );

endmodule

/* logic/complex_alu.sv */
`timescale 1ns/1ps

module complex_alu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cplx_pe_pkg::alu_req_t req,
    output cplx_pe_pkg::alu_rsp_t rsp
);
    import cplx_pe_pkg::*;

    // operand parts
    logic signed [15:0] a_re;
    logic signed [15:0] a_im;
    logic signed [15:0] b_re;
    logic signed [15:0] b_im;
    // 16-bit wrapped sums for add and sub
    logic signed [15:0] s_re;
    logic signed [15:0] s_im;

    // stage one registers
    logic               s1_v;
    opcode_e            s1_op;
    addr_t              s1_dst;
    logic signed [31:0] p_rr;
    logic signed [31:0] p_ii;
    logic signed [31:0] p_ri;
    logic signed [31:0] p_ir;

    // stage two combine
    logic signed [32:0] m_re;
    logic signed [32:0] m_im;
    logic signed [32:0] m_re_sh;
    logic signed [32:0] m_im_sh;
    cplx_t              s2_res;

    // stage two registers
    logic               rsp_v;
    addr_t              rsp_dst;
    cplx_t              rsp_res;

    assign a_re = req.a[31:16];
    assign a_im = req.a[15:0];
    assign b_re = req.b[31:16];
    assign b_im = req.b[15:0];
    assign s_re = (req.op == OP_SUB) ? a_re - b_re : a_re + b_re;
    assign s_im = (req.op == OP_SUB) ? a_im - b_im : a_im + b_im;

    ////////////////////////////////////////////////////////////
    // stage one forms partial products or sums
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_v  <= 1'b0;
            s1_op <= OP_ADD;
        end else begin
            s1_v  <= req.valid;
            s1_op <= req.op;
        end
    end

    always_ff @(posedge clk) begin
        s1_dst <= req.dst;
        if (req.valid && (req.op == OP_MUL)) begin
            p_rr <= a_re * b_re;
            p_ii <= a_im * b_im;
            p_ri <= a_re * b_im;
            p_ir <= a_im * b_re;
        end else if (req.valid) begin
            // sums ride in the low halves of p_rr and p_ri
            p_rr <= {16'h0000, s_re};
            p_ri <= {16'h0000, s_im};
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two combines and scales
    ////////////////////////////////////////////////////////////

    always_comb begin
        // (ar + j ai)(br + j bi)
        // 33 bits hold the full range
        m_re    = p_rr - p_ii;
        m_im    = p_ri + p_ir;
        // back to q1.15 keeping 16 bits
        m_re_sh = m_re >>> 15;
        m_im_sh = m_im >>> 15;
        if (s1_op == OP_MUL) begin
            s2_res = {m_re_sh[15:0], m_im_sh[15:0]};
        end else begin
            s2_res = {p_rr[15:0], p_ri[15:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_v <= 1'b0;
        end else begin
            rsp_v <= s1_v;
        end
    end

    always_ff @(posedge clk) begin
        rsp_dst <= s1_dst;
        rsp_res <= s2_res;
    end

    assign rsp = '{valid: rsp_v, dst: rsp_dst, result: rsp_res};

    // control only sends arithmetic here
    a_op_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        req.valid |-> (req.op inside {OP_ADD, OP_SUB, OP_MUL})
    );

endmodule

/* logic/pe_data_mem.sv */
`timescale 1ns/1ps

module pe_data_mem (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               we,
    input  cplx_pe_pkg::addr_t waddr,
    input  cplx_pe_pkg::cplx_t wdata,
    input  cplx_pe_pkg::addr_t raddr_a,
    input  cplx_pe_pkg::addr_t raddr_b,
    output cplx_pe_pkg::cplx_t rdata_a,
    output cplx_pe_pkg::cplx_t rdata_b
);
    import cplx_pe_pkg::*;

    // one word per address
    localparam int WORDS = 2 ** $bits(addr_t);

    cplx_t mem [WORDS];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // whole array clears to zero on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // port a, write-first bypass
    always_comb begin
        rdata_a = mem[raddr_a];
        if (we && (waddr == raddr_a)) begin
            rdata_a = wdata;
        end
    end

    // port b, same bypass
    always_comb begin
        rdata_b = mem[raddr_b];
        if (we && (waddr == raddr_b)) begin
            rdata_b = wdata;
        end
    end

endmodule

/* logic/pe_inst_mem.sv */
`timescale 1ns/1ps

module pe_inst_mem #(
    parameter int PROG_DEPTH = 16
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_v,
    input  cplx_pe_pkg::inst_t inst,
    input  logic               start,
    input  logic               pc_step,
    output cplx_pe_pkg::inst_t cur_inst,
    output logic               pc_end
);
    import cplx_pe_pkg::*;

    // program storage
    inst_t mem [PROG_DEPTH];

    // pointer and length one bit wider than pc, a full program is PROG_DEPTH words
    logic [$bits(pc_t):0] wr_ptr;
    logic [$bits(pc_t):0] prog_len;
    pc_t                  pc;
    // set once the last slot has been stepped past
    logic                 pc_over;
    // counter is advancing through a program
    logic                 running;
    logic                 run_start;
    logic                 wr_ok;

    // start while running is ignored
    assign run_start = start && !running;
    assign wr_ok     = inst_v && (wr_ptr < PROG_DEPTH);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[$bits(pc_t)-1:0]] <= inst;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            prog_len <= '0;
            pc       <= '0;
            pc_over  <= 1'b0;
            running  <= 1'b0;
        end else if (run_start) begin
            // latch program length, rewind both pointers
            prog_len <= wr_ptr;
            wr_ptr   <= '0;
            pc       <= '0;
            pc_over  <= 1'b0;
            running  <= 1'b1;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pc_step && !pc_end) begin
                if (pc == pc_t'(PROG_DEPTH - 1)) begin
                    pc_over <= 1'b1;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
            // counter stops at halt or any unknown opcode
            if (running && !(cur_inst.opcode inside {OP_ADD, OP_SUB, OP_MUL, OP_OUT})) begin
                running <= 1'b0;
            end
        end
    end

    // past the loaded words reads as halt
    assign pc_end   = pc_over || ({1'b0, pc} >= prog_len);
    assign cur_inst = pc_end ? '{opcode: OP_HALT, default: '0} : mem[pc];

    // host must not load a program under a running counter
    a_no_load_running: assert property (
        @(posedge clk) disable iff (!arst_n) running |-> !inst_v
    );

endmodule

/* logic/cplx_pe_pkg.sv */
package cplx_pe_pkg;

    ////////////////////////////////////////////////////////////
    // data and address widths
    ////////////////////////////////////////////////////////////

    // complex word, real part in [31:16], imag part in [15:0]
    // both parts signed q1.15
    typedef logic [31:0] cplx_t;

    // data memory address, 32 words
    typedef logic [4:0] addr_t;

    // program counter, up to 16 instructions
    typedef logic [3:0] pc_t;

    // instruction opcodes
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_OUT  = 3'd3,
        OP_HALT = 3'd4
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // instruction and alu interface words
    ////////////////////////////////////////////////////////////

    // 24-bit instruction, spare bits kept at zero
    typedef struct packed {
        opcode_e    opcode;
        addr_t      dst;
        addr_t      src_a;
        addr_t      src_b;
        logic [5:0] spare;
    } inst_t;

    // request into the alu, operands already read
    typedef struct packed {
        logic    valid;
        opcode_e op;
        addr_t   dst;
        cplx_t   a;
        cplx_t   b;
    } alu_req_t;

    // result out of the alu with its destination tag
    typedef struct packed {
        logic  valid;
        addr_t dst;
        cplx_t result;
    } alu_rsp_t;

    // alu pipeline depth in cycles
    localparam int ALU_LAT = 2;

endpackage
